/* src/synctimer_pkg.sv */
package synctimer_pkg;

    localparam int TIMER_WIDTH = 64;

    // clock period is NUMERATOR/DENOMINATOR ns
    localparam int NUMERATOR   = 10;
    localparam int DENOMINATOR = 3;

    localparam int OFFSET_WIDTH    = 24;
    localparam int OFFSET_LPF_GAIN = 4;   // filter weight 1/2^(G+1) on new samples

    // two clock cycles of time, rounded down
    localparam int TX_START_CORR = (2 * NUMERATOR) / DENOMINATOR;

    // holds remainder plus numerator before the divide
    localparam int ACC_WIDTH = $clog2(NUMERATOR + DENOMINATOR);

    typedef logic [TIMER_WIDTH-1:0]  t_time;
    typedef logic [OFFSET_WIDTH-1:0] t_offset;
    typedef logic [ACC_WIDTH-1:0]    t_acc;

endpackage

/* src/frame_pkg.sv */
package frame_pkg;

    localparam int MAX_NODES = 2;

    // command byte, 8 time bytes, then 4 bytes per node
    localparam int TIME_POS   = 1;
    localparam int TIME_BYTES = 8;
    localparam int NODE_BYTES = 4;
    localparam int OFFSET_POS = TIME_POS + TIME_BYTES;
    localparam int CMD_LEN    = OFFSET_POS + NODE_BYTES * MAX_NODES;

    // must also count one past the last byte
    localparam int CMD_CNT_WIDTH = $clog2(CMD_LEN + 1);

    typedef logic [CMD_CNT_WIDTH-1:0] t_cmd_count;

    typedef synctimer_pkg::t_offset [MAX_NODES-1:0] t_node_offsets;

    typedef struct packed {
        logic       last;
        logic [7:0] data;
    } t_cmd_beat;

    typedef struct packed {
        logic [15:0] pos;   // byte position within the frame
        logic [7:0]  data;
    } t_res_beat;

endpackage

/* src/synctimer_timer.sv */
module synctimer_timer (
    input  logic                 clk,
    input  logic                 reset,
    input  synctimer_pkg::t_time set_time,
    input  logic                 set_valid,
    output synctimer_pkg::t_time current_time
);

    synctimer_pkg::t_acc rem;
    synctimer_pkg::t_acc acc;
    synctimer_pkg::t_acc step;
    synctimer_pkg::t_acc rem_next;

    // integer part of the period goes to the time, the rest carries over
    assign acc      = rem + synctimer_pkg::t_acc'(synctimer_pkg::NUMERATOR);
    assign step     = synctimer_pkg::t_acc'(acc / synctimer_pkg::DENOMINATOR);
    assign rem_next = synctimer_pkg::t_acc'(acc % synctimer_pkg::DENOMINATOR);

    always_ff @(posedge clk) begin
        if (reset) begin
            current_time <= '0;
            rem          <= '0;
        end else if (set_valid) begin
            current_time <= set_time;
            rem          <= '0;
        end else begin
            current_time <= current_time + synctimer_pkg::t_time'(step);
            rem          <= rem_next;
        end
    end

endmodule

/* src/cmd_frame_tx.sv */
module cmd_frame_tx (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     cmd_start,
    input  logic                     cmd_renew,
    input  logic                     cmd_correct,
    input  synctimer_pkg::t_time     current_time,
    input  frame_pkg::t_node_offsets node_offsets,
    output logic                     cmd_valid,
    output frame_pkg::t_cmd_beat     cmd_beat,
    input  logic                     cmd_ready
);

    logic                  busy;
    frame_pkg::t_cmd_count count;
    logic [7:0]            cmd_byte;
    logic [frame_pkg::TIME_BYTES-1:0][7:0] time_bytes;
    logic [frame_pkg::MAX_NODES-1:0][frame_pkg::NODE_BYTES-1:0][7:0] offset_bytes;
    logic                  cke;
    logic                  accept;
    logic                  at_last;
    logic [7:0]            next_data;

    assign cke     = !cmd_valid || cmd_ready;
    assign accept  = cmd_start && !busy && !cmd_valid;   // nothing in flight
    assign at_last = (count == frame_pkg::t_cmd_count'(frame_pkg::CMD_LEN - 1));

    always_comb begin
        next_data = cmd_byte;
        for (int i = 0; i < frame_pkg::TIME_BYTES; i++) begin
            if (count == frame_pkg::TIME_POS + i) begin
                next_data = time_bytes[i];
            end
        end
        for (int i = 0; i < frame_pkg::MAX_NODES; i++) begin
            for (int j = 0; j < frame_pkg::NODE_BYTES; j++) begin
                if (count == frame_pkg::OFFSET_POS + frame_pkg::NODE_BYTES * i + j) begin
                    next_data = offset_bytes[i][j];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy      <= 1'b0;
            count     <= '0;
            cmd_valid <= 1'b0;
        end else begin
            if (accept) begin
                busy  <= 1'b1;
                count <= '0;
            end else if (cke && busy) begin
                count <= count + 1'b1;
                if (at_last) busy <= 1'b0;
            end
            if (cke) cmd_valid <= busy;
        end
    end

    // frame snapshot
    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_byte   <= {6'd0, cmd_renew, cmd_correct};
            time_bytes <= current_time;
            for (int i = 0; i < frame_pkg::MAX_NODES; i++) begin
                offset_bytes[i] <= 32'(node_offsets[i]);   // zero-extended field
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cke) begin
            cmd_beat.data <= next_data;
            cmd_beat.last <= at_last;
        end
    end

endmodule

/* src/res_frame_rx.sv */
module res_frame_rx (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     res_start,
    input  logic                     res_end,
    input  logic                     res_error,
    input  logic                     res_valid,
    input  frame_pkg::t_res_beat     res_beat,
    output frame_pkg::t_node_offsets rx_offsets,
    output logic                     res_done
);

    logic in_frame;

    always_ff @(posedge clk) begin
        if (reset) begin
            in_frame <= 1'b0;
            res_done <= 1'b0;
        end else begin
            if (res_start) in_frame <= 1'b1;
            else if (res_end) in_frame <= 1'b0;
            res_done <= res_end && !res_error;   // error frames are dropped
        end
    end

    // upper bytes of the 32-bit field do not fit and are skipped
    always_ff @(posedge clk) begin
        if (res_valid && (in_frame || res_start)) begin
            for (int i = 0; i < frame_pkg::MAX_NODES; i++) begin
                for (int j = 0; j < synctimer_pkg::OFFSET_WIDTH / 8; j++) begin
                    if (res_beat.pos ==
                        frame_pkg::OFFSET_POS + frame_pkg::NODE_BYTES * i + j) begin
                        rx_offsets[i][8*j +: 8] <= res_beat.data;
                    end
                end
            end
        end
    end

endmodule

/* src/offset_estimator.sv */
module offset_estimator (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     cmd_start,
    input  logic                     res_start,
    input  logic                     res_end,
    input  logic                     res_done,
    input  synctimer_pkg::t_time     current_time,
    input  frame_pkg::t_node_offsets rx_offsets,
    output frame_pkg::t_node_offsets node_offsets,
    output logic                     offset_update
);

    localparam int SHIFT = synctimer_pkg::OFFSET_LPF_GAIN + 1;

    synctimer_pkg::t_offset   now;
    synctimer_pkg::t_offset   tx_start;
    synctimer_pkg::t_offset   rx_start;
    synctimer_pkg::t_offset   response;
    synctimer_pkg::t_offset   packet;
    frame_pkg::t_node_offsets delay;
    frame_pkg::t_node_offsets measured;
    frame_pkg::t_node_offsets filtered;
    logic                     first;
    logic                     stage1;
    logic                     stage2;

    assign now = synctimer_pkg::t_offset'(current_time);

    always_ff @(posedge clk) begin
        if (cmd_start) tx_start <= now - synctimer_pkg::t_offset'(synctimer_pkg::TX_START_CORR);
        if (res_start) begin
            rx_start <= now;
            response <= now - tx_start;
        end
        if (res_end) packet <= now - rx_start;
    end

    // offset*(2^(G+1)-2) + measured, wrapped before the shift
    always_comb begin
        for (int i = 0; i < frame_pkg::MAX_NODES; i++) begin
            filtered[i] = synctimer_pkg::t_offset'((node_offsets[i] << SHIFT)
                        - (node_offsets[i] << 1) + measured[i]) >> SHIFT;
        end
    end

    always_ff @(posedge clk) begin
        if (res_done) begin
            for (int i = 0; i < frame_pkg::MAX_NODES; i++) begin
                delay[i] <= response - rx_offsets[i];
            end
        end
        if (stage1) begin
            for (int i = 0; i < frame_pkg::MAX_NODES; i++) begin
                measured[i] <= delay[i] + (packet << 1);   // packet time counts twice
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stage1        <= 1'b0;
            stage2        <= 1'b0;
            offset_update <= 1'b0;
            first         <= 1'b1;
            node_offsets  <= '0;
        end else begin
            stage1        <= res_done;
            stage2        <= stage1;
            offset_update <= stage2;
            if (stage2) begin
                first <= 1'b0;
                for (int i = 0; i < frame_pkg::MAX_NODES; i++) begin
                    node_offsets[i] <= first ? (measured[i] >> 1) : filtered[i];
                end
            end
        end
    end

endmodule

/* src/synctimer_master.sv */
module synctimer_master (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     set_valid,
    input  synctimer_pkg::t_time     set_time,
    input  logic                     cmd_start,
    input  logic                     cmd_renew,
    input  logic                     cmd_correct,
    input  logic                     res_start,
    input  logic                     res_end,
    input  logic                     res_error,
    input  logic                     res_valid,
    input  frame_pkg::t_res_beat     res_beat,
    output synctimer_pkg::t_time     current_time,
    output logic                     cmd_valid,
    output frame_pkg::t_cmd_beat     cmd_beat,
    input  logic                     cmd_ready,
    output frame_pkg::t_node_offsets node_offsets,
    output logic                     offset_update
);

    frame_pkg::t_node_offsets rx_offsets;
    logic                     res_done;

    synctimer_timer u_timer (
        .clk          (clk),
        .reset        (reset),
        .set_time     (set_time),
        .set_valid    (set_valid),
        .current_time (current_time)
    );

    cmd_frame_tx u_tx (
        .clk          (clk),
        .reset        (reset),
        .cmd_start    (cmd_start),
        .cmd_renew    (cmd_renew),
        .cmd_correct  (cmd_correct),
        .current_time (current_time),
        .node_offsets (node_offsets),
        .cmd_valid    (cmd_valid),
        .cmd_beat     (cmd_beat),
        .cmd_ready    (cmd_ready)
    );

    res_frame_rx u_rx (
        .clk        (clk),
        .reset      (reset),
        .res_start  (res_start),
        .res_end    (res_end),
        .res_error  (res_error),
        .res_valid  (res_valid),
        .res_beat   (res_beat),
        .rx_offsets (rx_offsets),
        .res_done   (res_done)
    );

    offset_estimator u_est (
        .clk           (clk),
        .reset         (reset),
        .cmd_start     (cmd_start),
        .res_start     (res_start),
        .res_end       (res_end),
        .res_done      (res_done),
        .current_time  (current_time),
        .rx_offsets    (rx_offsets),
        .node_offsets  (node_offsets),
        .offset_update (offset_update)
    );

endmodule

/* bench/synctimer_master_asserts.sv */
module synctimer_master_asserts (
    input logic                 clk,
    input logic                 reset,
    input logic                 cmd_valid,
    input logic                 cmd_ready,
    input frame_pkg::t_cmd_beat cmd_beat,
    input logic                 res_end,
    input logic                 res_error,
    input logic                 offset_update
);
    timeunit 1ns;
    timeprecision 100ps;

    // a stalled beat stays put
    stall_hold: assert property (@(posedge clk) disable iff (reset)
        cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd_beat))
        else $error("command beat changed while cmd_ready was low");

    reset_idle: assert property (@(posedge clk) reset |=> !cmd_valid)
        else $error("cmd_valid high in the cycle after reset");

    update_latency: assert property (@(posedge clk) disable iff (reset)
        res_end && !res_error |-> ##4 offset_update)
        else $error("offset_update missing 4 cycles after res_end");

    update_cause: assert property (@(posedge clk) disable iff (reset)
        offset_update |-> $past(res_end && !res_error, 4))
        else $error("offset_update without a clean res_end 4 cycles before");

endmodule

bind synctimer_master synctimer_master_asserts u_asserts (.*);

/* bench/tb_synctimer_master.sv */
module tb_synctimer_master;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int ROUNDS    = 40;
    localparam int MAX_DELAY = 16;   // longest response delay in cycles
    localparam int CMD_LEN   = frame_pkg::CMD_LEN;
    localparam int G         = synctimer_pkg::OFFSET_LPF_GAIN;
    localparam int WATCHDOG_CYCLES = ROUNDS * (CMD_LEN * 8 + MAX_DELAY + 40) + 20;

    logic clk;
    logic reset;
    logic set_valid, cmd_start, cmd_renew, cmd_correct, cmd_ready;
    logic res_start, res_end, res_error, res_valid;
    synctimer_pkg::t_time     set_time;
    synctimer_pkg::t_time     current_time;
    frame_pkg::t_res_beat     res_beat;
    frame_pkg::t_cmd_beat     cmd_beat;
    frame_pkg::t_node_offsets node_offsets;
    logic cmd_valid, offset_update;

    // reference model state
    logic [31:0]              lcg_state = 32'd18232;
    synctimer_pkg::t_time     m_time;
    int                       m_rem;
    frame_pkg::t_node_offsets m_offsets, m_rx, m_measured;
    logic                     m_first;
    synctimer_pkg::t_offset   tx_start, rx_start, response, packet;
    int                       countdown;
    logic                     exp_update, frame_active, transfer;
    logic [8:0]               exp_beats[$];   // {last, data}

    synctimer_master u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_below(int n);
        return int'(next_rand() >> 8) % n;
    endfunction

    // byte k of a command frame built from the current model snapshot
    function automatic logic [7:0] frame_byte(int k);
        logic [31:0] field;
        if (k == 0) return {6'd0, cmd_renew, cmd_correct};
        if (k < frame_pkg::OFFSET_POS) return m_time[8*(k-1) +: 8];
        field = 32'(m_offsets[(k - frame_pkg::OFFSET_POS) / 4]);
        return field[8*((k - frame_pkg::OFFSET_POS) % 4) +: 8];
    endfunction

    function automatic synctimer_pkg::t_offset low_pass_step(synctimer_pkg::t_offset off,
                                                             synctimer_pkg::t_offset meas);
        synctimer_pkg::t_offset sum;
        sum = off * ((1 << (G + 1)) - 2) + meas;   // wraps to offset width first
        return sum >> (G + 1);
    endfunction

    task automatic check_value(string name, logic [63:0] actual, logic [63:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %s: got %h, expected %h", name, actual, expected);
            $display("Done: errors found");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // one clock of output checks, model update at the edge and strobe release
    task automatic cycle();
        logic [8:0]             exp;
        synctimer_pkg::t_offset now;
        int                     p;
        exp = '0;
        #5;
        check_value("current_time", current_time, m_time);
        check_value("node_offsets", node_offsets, m_offsets);
        check_value("offset_update", offset_update, exp_update);
        transfer = cmd_valid && cmd_ready;
        if (transfer) begin
            if (exp_beats.size() == 0) begin
                $display("command beat accepted while no frame was pending");
                $display("Done: errors found");
                $fatal(1, "extra command frame");
            end
            exp = exp_beats.pop_front();
            check_value("cmd_beat", cmd_beat, exp);
        end
        @(posedge clk);
        now = synctimer_pkg::t_offset'(m_time);
        exp_update = 1'b0;
        if (cmd_start) begin
            tx_start = now - synctimer_pkg::t_offset'(synctimer_pkg::TX_START_CORR);
            if (!frame_active) begin
                for (int k = 0; k < CMD_LEN; k++) begin
                    exp_beats.push_back({k == CMD_LEN - 1, frame_byte(k)});
                end
                frame_active = 1'b1;
            end
        end
        if (transfer && exp[8]) frame_active = 1'b0;
        if (res_start) begin
            response = now - tx_start;
            rx_start = now;
        end
        p = int'(res_beat.pos) - frame_pkg::OFFSET_POS;
        if (res_valid && p >= 0 && p < 4 * frame_pkg::MAX_NODES && p % 4 < 3) begin
            m_rx[p / 4][8*(p % 4) +: 8] = res_beat.data;
        end
        if (countdown > 0) begin
            countdown--;
            if (countdown == 0) begin
                for (int i = 0; i < frame_pkg::MAX_NODES; i++) begin
                    m_offsets[i] = m_first ? m_measured[i] >> 1
                                           : low_pass_step(m_offsets[i], m_measured[i]);
                end
                m_first    = 1'b0;
                exp_update = 1'b1;
            end
        end
        if (res_end) begin
            packet = now - rx_start;
            if (!res_error) begin
                for (int i = 0; i < frame_pkg::MAX_NODES; i++) begin
                    m_measured[i] = response - m_rx[i] + (packet << 1);
                end
                countdown = 3;
            end
        end
        if (set_valid) begin
            m_time = set_time;
            m_rem  = 0;
        end else begin
            m_time = m_time + (m_rem + synctimer_pkg::NUMERATOR) / synctimer_pkg::DENOMINATOR;
            m_rem  = (m_rem + synctimer_pkg::NUMERATOR) % synctimer_pkg::DENOMINATOR;
        end
        #2;
        set_valid = 1'b0;
        cmd_start = 1'b0;
        res_start = 1'b0;
        res_end   = 1'b0;
        res_error = 1'b0;
        res_valid = 1'b0;
        cmd_ready = rand_below(10) < 7;
    endtask

    task automatic send_response();
        repeat (rand_below(MAX_DELAY + 1)) cycle();
        res_start = 1'b1;
        cycle();
        for (int p = 0; p < CMD_LEN; p++) begin
            res_valid     = 1'b1;
            res_beat.pos  = 16'(p);
            res_beat.data = 8'(next_rand() >> 12);
            cycle();
        end
        res_end   = 1'b1;
        res_error = rand_below(5) == 0;   // dropped frame
        cycle();
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Done: errors found");
        $fatal(1, "watchdog expired");
    end

    initial begin
        reset = 1'b1;
        {set_valid, cmd_start, cmd_renew, cmd_correct, cmd_ready} = '0;
        {res_start, res_end, res_error, res_valid} = '0;
        set_time     = '0;
        res_beat     = '0;
        m_time       = '0;
        m_rem        = 0;
        m_offsets    = '0;
        m_rx         = '0;
        m_measured   = '0;
        m_first      = 1'b1;
        countdown    = 0;
        exp_update   = 1'b0;
        frame_active = 1'b0;
        repeat (10) @(posedge clk);
        #2;
        reset = 1'b0;
        for (int r = 0; r < ROUNDS; r++) begin
            if (rand_below(2) == 0) begin
                set_valid = 1'b1;
                set_time  = {next_rand(), next_rand()};
                cycle();
            end
            repeat (rand_below(6)) cycle();
            cmd_start   = 1'b1;
            cmd_renew   = rand_below(2) == 1;
            cmd_correct = rand_below(2) == 1;
            cycle();
            while (frame_active) begin
                if (rand_below(8) == 0) begin
                    cmd_start = 1'b1;   // restart attempt while busy
                    cmd_renew = rand_below(2) == 1;
                end
                cycle();
            end
            send_response();
            repeat (6) cycle();
        end
        $display("Done: no errors");
        $finish;
    end

endmodule

/* src.f */
src/synctimer_pkg.sv
src/frame_pkg.sv
src/synctimer_timer.sv
src/cmd_frame_tx.sv
src/res_frame_rx.sv
src/offset_estimator.sv
src/synctimer_master.sv
bench/synctimer_master_asserts.sv
bench/tb_synctimer_master.sv

/* Bender.yml */
package:
  name: synctimer_master

sources:
  - src/synctimer_pkg.sv
  - src/frame_pkg.sv
  - src/synctimer_timer.sv
  - src/cmd_frame_tx.sv
  - src/res_frame_rx.sv
  - src/offset_estimator.sv
  - src/synctimer_master.sv
  - target: test
    files:
      - bench/synctimer_master_asserts.sv
      - bench/tb_synctimer_master.sv
